//--- logic/muldiv_pkg.sv
// M-extension funct3 type and codes, divider state enum and default data width.

package muldiv_pkg;

	// ******************************
	// Data width
	// ******************************
	localparam int DATA_WIDTH_DEF = 32; // RV32 operand width.

	// ******************************
	// Operation selector
	// ******************************
	typedef logic [2:0] funct3_t; // funct3 field of an M-extension instruction.

	// Multiply codes return one half of the double-width product.
	localparam funct3_t FUNCT3_MUL    = 3'd0; // SxS low half.
	localparam funct3_t FUNCT3_MULH   = 3'd1; // SxS high half.
	localparam funct3_t FUNCT3_MULHSU = 3'd2; // SxU high half.
	localparam funct3_t FUNCT3_MULHU  = 3'd3; // UxU high half.

	// Divide codes, bit 2 set for all four.
	// Bit 0 set means unsigned, bit 1 set means remainder.
	localparam funct3_t FUNCT3_DIV    = 3'd4; // Signed quotient.
	localparam funct3_t FUNCT3_DIVU   = 3'd5; // Unsigned quotient.
	localparam funct3_t FUNCT3_REM    = 3'd6; // Signed remainder.
	localparam funct3_t FUNCT3_REMU   = 3'd7; // Unsigned remainder.

	// ******************************
	// Divider FSM
	// ******************************
	typedef enum logic {
		DIV_IDLE, // Waiting for a start, results held.
		DIV_RUN   // Iterating one quotient bit per cycle.
	} div_state_e;

endpackage

//--- logic/operand_unsign.sv
// Operand signedness decode, magnitudes and divide special-case flags.

module operand_unsign #(
	parameter int DATA_WIDTH = muldiv_pkg::DATA_WIDTH_DEF
) (
	input  logic [DATA_WIDTH-1:0] rs1_i,       // Multiplicand or dividend.
	input  logic [DATA_WIDTH-1:0] rs2_i,       // Multiplier or divisor.
	input  muldiv_pkg::funct3_t   funct3_i,    // Operation selector.
	output logic                  a_signed_o,  // rs1 taken as signed.
	output logic                  b_signed_o,  // rs2 taken as signed.
	output logic [DATA_WIDTH-1:0] a_mag_o,     // Magnitude of rs1.
	output logic [DATA_WIDTH-1:0] b_mag_o,     // Magnitude of rs2.
	output logic                  div_zero_o,  // Divisor is zero.
	output logic                  div_ovf_o,   // Signed overflow, most negative by minus one.
	output logic                  sign_diff_o  // Operand signs differ.
);
	import muldiv_pkg::*;

	localparam logic [DATA_WIDTH-1:0] MOST_NEG = {1'b1, {(DATA_WIDTH-1){1'b0}}};

	logic a_neg; // rs1 is a negative signed value.
	logic b_neg; // rs2 is a negative signed value.

	// ******************************
	// Signedness
	// ******************************
	// rs2 is signed for MUL, MULH, DIV and REM.
	assign b_signed_o = (funct3_i == FUNCT3_MUL) | (funct3_i == FUNCT3_MULH) |
		(funct3_i == FUNCT3_DIV) | (funct3_i == FUNCT3_REM);
	// rs1 adds MULHSU to that set.
	assign a_signed_o = b_signed_o | (funct3_i == FUNCT3_MULHSU);

	assign a_neg = a_signed_o & rs1_i[DATA_WIDTH-1];
	assign b_neg = b_signed_o & rs2_i[DATA_WIDTH-1];

	// ******************************
	// Magnitudes
	// ******************************
	// Two's complement only when the operand is signed and negative.
	assign a_mag_o = a_neg ? (~rs1_i + 1'b1) : rs1_i;
	assign b_mag_o = b_neg ? (~rs2_i + 1'b1) : rs2_i;

	// ******************************
	// Special cases
	// ******************************
	assign div_zero_o = (rs2_i == '0); // Any divide by zero.

	// Quotient 2^(W-1) does not fit, only for the signed codes.
	assign div_ovf_o = b_signed_o & (rs1_i == MOST_NEG) & (rs2_i == '1);

	// Sign of the signed quotient.
	assign sign_diff_o = rs1_i[DATA_WIDTH-1] ^ rs2_i[DATA_WIDTH-1];

endmodule

//--- logic/mul_array.sv
// Registered signed, mixed and unsigned multiplier of the two operands.

module mul_array #(
	parameter int DATA_WIDTH = muldiv_pkg::DATA_WIDTH_DEF
) (
	input  logic                    clk,
	input  logic                    rstLow,     // Asynchronous, active low.
	input  logic [DATA_WIDTH-1:0]   a_i,        // Raw rs1.
	input  logic [DATA_WIDTH-1:0]   b_i,        // Raw rs2.
	input  logic                    a_signed_i, // Treat a_i as signed.
	input  logic                    b_signed_i, // Treat b_i as signed.
	output logic [2*DATA_WIDTH-1:0] product_o   // Registered product.
);

	localparam int EXT_W  = DATA_WIDTH + 1;   // One guard bit per operand.
	localparam int FULL_W = 2 * EXT_W;        // Full width of the extended product.

	logic signed [EXT_W-1:0]  a_ext;   // rs1 with sign or zero extension.
	logic signed [EXT_W-1:0]  b_ext;   // rs2 with sign or zero extension.
	logic signed [FULL_W-1:0] prod_full;

	// ******************************
	// Operand extension
	// ******************************
	// The extra bit copies the sign only for a signed operand.
	// An unsigned operand gets a zero and stays positive.
	assign a_ext = {a_signed_i & a_i[DATA_WIDTH-1], a_i};
	assign b_ext = {b_signed_i & b_i[DATA_WIDTH-1], b_i};

	// ******************************
	// Multiply
	// ******************************
	// One signed multiply covers all three forms.
	assign prod_full = a_ext * b_ext;

	// Two guard bits on top are never needed for the result.
	always_ff @(posedge clk or negedge rstLow) begin
		if (!rstLow) begin
			product_o <= '0;
		end else begin
			product_o <= prod_full[2*DATA_WIDTH-1:0]; // Every clock, no enable.
		end
	end

endmodule

//--- logic/div_restoring.sv
// Unsigned restoring divider, one quotient bit per cycle.

module div_restoring #(
	parameter int DATA_WIDTH = muldiv_pkg::DATA_WIDTH_DEF
) (
	input  logic                  clk,
	input  logic                  rstLow,      // Asynchronous, active low.
	input  logic                  start_i,     // One-cycle start pulse.
	input  logic [DATA_WIDTH-1:0] dividend_i,  // Unsigned dividend.
	input  logic [DATA_WIDTH-1:0] divisor_i,   // Unsigned, nonzero divisor.
	output logic [DATA_WIDTH-1:0] quotient_o,  // Held until next start.
	output logic [DATA_WIDTH-1:0] remainder_o, // Held until next start.
	output logic                  busy_o       // High while iterating.
);
	import muldiv_pkg::*;

	localparam int                CNT_W     = $clog2(DATA_WIDTH);
	localparam logic [CNT_W-1:0]  LAST_ITER = CNT_W'(DATA_WIDTH - 1);

	div_state_e            state_q;  // FSM state.
	logic [CNT_W-1:0]      count_q;  // Iteration index.
	logic [DATA_WIDTH-1:0] rem_q;    // Partial remainder.
	logic [DATA_WIDTH-1:0] quo_q;    // Dividend bits out on top, quotient bits in below.
	logic [DATA_WIDTH-1:0] dsr_q;    // Latched divisor.
	logic [DATA_WIDTH:0]   shifted;  // Partial remainder with next dividend bit.
	logic [DATA_WIDTH:0]   trial;    // Trial subtraction.
	logic                  q_bit;    // New quotient bit.

	// ******************************
	// Trial subtraction
	// ******************************
	assign shifted = {rem_q, quo_q[DATA_WIDTH-1]};
	assign trial   = shifted - {1'b0, dsr_q};
	assign q_bit   = ~trial[DATA_WIDTH]; // No borrow, divisor fits.

	// ******************************
	// FSM and counter
	// ******************************
	always_ff @(posedge clk or negedge rstLow) begin
		if (!rstLow) begin
			state_q <= DIV_IDLE;
			count_q <= '0;
		end else begin
			case (state_q)
				DIV_IDLE: begin
					if (start_i) begin
						state_q <= DIV_RUN; // Load cycle, no iteration yet.
						count_q <= '0;
					end
				end
				DIV_RUN: begin
					if (count_q == LAST_ITER) begin
						state_q <= DIV_IDLE; // Last bit decided.
					end
					count_q <= count_q + 1'b1;
				end
				default: state_q <= DIV_IDLE;
			endcase
		end
	end

	// ******************************
	// Datapath
	// ******************************
	always_ff @(posedge clk) begin
		if ((state_q == DIV_IDLE) && start_i) begin
			rem_q <= '0;
			quo_q <= dividend_i;
			dsr_q <= divisor_i;
		end else if (state_q == DIV_RUN) begin
			// Keep the difference only when the subtraction did not borrow.
			rem_q <= q_bit ? trial[DATA_WIDTH-1:0] : shifted[DATA_WIDTH-1:0];
			quo_q <= {quo_q[DATA_WIDTH-2:0], q_bit};
		end
	end

	assign quotient_o  = quo_q;
	assign remainder_o = rem_q;
	assign busy_o      = (state_q == DIV_RUN);

endmodule

//--- logic/muldiv_control.sv
// Divider start pulse, remembered operands for single-cycle remainders and busy level.

module muldiv_control #(
	parameter int DATA_WIDTH = muldiv_pkg::DATA_WIDTH_DEF
) (
	input  logic                  clk,
	input  logic                  rstLow,      // Asynchronous, active low.
	input  logic                  start_i,     // Request strobe from the core.
	input  muldiv_pkg::funct3_t   funct3_i,    // Operation selector.
	input  logic [DATA_WIDTH-1:0] rs1_i,       // Dividend.
	input  logic [DATA_WIDTH-1:0] rs2_i,       // Divisor.
	input  logic                  div_zero_i,  // Divide by zero.
	input  logic                  div_ovf_i,   // Signed overflow.
	input  logic                  div_busy_i,  // Divider running.
	output logic                  div_start_o, // One-cycle divider start.
	output logic                  busy_o       // Core must wait while high.
);
	import muldiv_pkg::*;

	logic [DATA_WIDTH-1:0] a_prev_q;      // Dividend of the last started divide.
	logic [DATA_WIDTH-1:0] b_prev_q;      // Divisor of the last started divide.
	funct3_t               funct3_prev_q; // Last request that was not a repeat.
	logic                  start_flag_q;  // Divide in flight.
	logic                  is_div;        // Any of the four divide codes.
	logic                  div_fast;      // Divide answered without the divider.
	logic                  repeat_rem;    // Remainder of the quotient just computed.

	// ******************************
	// Repeat detection
	// ******************************
	// REM pairs with DIV and REMU with DIVU, never across.
	assign repeat_rem = (((funct3_i == FUNCT3_REM) && (funct3_prev_q == FUNCT3_DIV)) ||
		((funct3_i == FUNCT3_REMU) && (funct3_prev_q == FUNCT3_DIVU))) &&
		(rs1_i == a_prev_q) && (rs2_i == b_prev_q);

	assign is_div   = funct3_i[2];
	assign div_fast = is_div & (div_zero_i | div_ovf_i | repeat_rem);

	// ******************************
	// Divider start
	// ******************************
	// Blocked while a divide is in flight, so a start during busy is dropped.
	assign div_start_o = start_i & is_div & ~div_fast & ~start_flag_q;

	// Set by the start, cleared once the divider has finished.
	always_ff @(posedge clk or negedge rstLow) begin
		if (!rstLow) begin
			start_flag_q <= 1'b0;
		end else begin
			start_flag_q <= start_flag_q ? div_busy_i : div_start_o;
		end
	end

	// ******************************
	// Remembered request
	// ******************************
	always_ff @(posedge clk or negedge rstLow) begin
		if (!rstLow) begin
			a_prev_q      <= '0;
			b_prev_q      <= '0;
			funct3_prev_q <= FUNCT3_MUL;
		end else begin
			if (div_start_o) begin
				a_prev_q <= rs1_i; // Operands behind the held divider results.
				b_prev_q <= rs2_i;
			end
			if (start_i && !repeat_rem) begin
				funct3_prev_q <= funct3_i; // A repeat keeps the pairing alive.
			end
		end
	end

	// Start cycle of anything but a fast divide, then the divider run.
	assign busy_o = (start_i & ~div_fast) | div_busy_i;

endmodule

//--- logic/muldiv_result.sv
// Sign correction, divide special cases and output select by funct3.

module muldiv_result #(
	parameter int DATA_WIDTH = muldiv_pkg::DATA_WIDTH_DEF
) (
	input  muldiv_pkg::funct3_t     funct3_i,    // Operation selector.
	input  logic [DATA_WIDTH-1:0]   rs1_i,       // Raw dividend.
	input  logic [2*DATA_WIDTH-1:0] product_i,   // Registered product.
	input  logic [DATA_WIDTH-1:0]   quotient_i,  // Unsigned quotient of magnitudes.
	input  logic [DATA_WIDTH-1:0]   remainder_i, // Unsigned remainder of magnitudes.
	input  logic                    div_zero_i,  // Divide by zero.
	input  logic                    div_ovf_i,   // Signed overflow.
	input  logic                    sign_diff_i, // Operand signs differ.
	output logic [DATA_WIDTH-1:0]   c_o          // Result to the core.
);
	import muldiv_pkg::*;

	logic                  unsigned_div; // DIVU or REMU.
	logic [DATA_WIDTH-1:0] q_signed;     // Quotient with sign applied.
	logic [DATA_WIDTH-1:0] r_signed;     // Remainder with sign applied.
	logic [DATA_WIDTH-1:0] q_out;        // Final quotient.
	logic [DATA_WIDTH-1:0] r_out;        // Final remainder.
	logic [DATA_WIDTH-1:0] prod_lo;
	logic [DATA_WIDTH-1:0] prod_hi;

	assign unsigned_div = funct3_i[0];

	// ******************************
	// Sign correction
	// ******************************
	// Quotient is negative when the signs differ.
	assign q_signed = sign_diff_i ? (~quotient_i + 1'b1) : quotient_i;

	// Remainder takes the dividend sign.
	// A zero remainder stays zero after negation.
	assign r_signed = rs1_i[DATA_WIDTH-1] ? (~remainder_i + 1'b1) : remainder_i;

	// ******************************
	// Special cases
	// ******************************
	always_comb begin
		if (div_zero_i) begin
			q_out = '1;    // Quotient of all ones.
			r_out = rs1_i; // Remainder is the dividend.
		end else if (div_ovf_i) begin
			q_out = rs1_i; // Most negative value back.
			r_out = '0;
		end else if (unsigned_div) begin
			q_out = quotient_i;
			r_out = remainder_i;
		end else begin
			q_out = q_signed;
			r_out = r_signed;
		end
	end

	// ******************************
	// Output select
	// ******************************
	assign prod_lo = product_i[DATA_WIDTH-1:0];
	assign prod_hi = product_i[2*DATA_WIDTH-1:DATA_WIDTH];

	always_comb begin
		case (funct3_i)
			FUNCT3_MUL:    c_o = prod_lo;
			FUNCT3_MULH:   c_o = prod_hi;
			FUNCT3_MULHSU: c_o = prod_hi; // Signedness already in the product.
			FUNCT3_MULHU:  c_o = prod_hi;
			FUNCT3_DIV:    c_o = q_out;
			FUNCT3_DIVU:   c_o = q_out;
			FUNCT3_REM:    c_o = r_out;
			FUNCT3_REMU:   c_o = r_out;
			default:       c_o = prod_lo;
		endcase
	end

endmodule

//--- logic/muldiv_unit.sv
// Top level of the M-extension multiply and divide unit.

module muldiv_unit #(
	parameter int DATA_WIDTH = muldiv_pkg::DATA_WIDTH_DEF
) (
	input  logic                  clk,
	input  logic                  rstLow,   // Asynchronous, active low.
	input  logic                  start_i,  // One-cycle request strobe.
	input  logic [DATA_WIDTH-1:0] rs1_i,    // Held until busy_o is low.
	input  logic [DATA_WIDTH-1:0] rs2_i,    // Held until busy_o is low.
	input  muldiv_pkg::funct3_t   funct3_i, // Operation selector.
	output logic [DATA_WIDTH-1:0] c_o,      // Valid while busy_o is low.
	output logic                  busy_o    // Core polls this level.
);

	logic                    a_signed;
	logic                    b_signed;
	logic [DATA_WIDTH-1:0]   a_mag;
	logic [DATA_WIDTH-1:0]   b_mag;
	logic                    div_zero;
	logic                    div_ovf;
	logic                    sign_diff;
	logic [2*DATA_WIDTH-1:0] product;
	logic [DATA_WIDTH-1:0]   quotient;
	logic [DATA_WIDTH-1:0]   remainder;
	logic                    div_start;
	logic                    div_busy;

	// ******************************
	// Operand decode
	// ******************************
	operand_unsign #(.DATA_WIDTH(DATA_WIDTH)) u_operand_unsign (
		.rs1_i(rs1_i), .rs2_i(rs2_i), .funct3_i(funct3_i),
		.a_signed_o(a_signed), .b_signed_o(b_signed),
		.a_mag_o(a_mag), .b_mag_o(b_mag),
		.div_zero_o(div_zero), .div_ovf_o(div_ovf), .sign_diff_o(sign_diff)
	);

	// ******************************
	// Arithmetic
	// ******************************
	mul_array #(.DATA_WIDTH(DATA_WIDTH)) u_mul_array (
		.clk(clk), .rstLow(rstLow), .a_i(rs1_i), .b_i(rs2_i),
		.a_signed_i(a_signed), .b_signed_i(b_signed), .product_o(product)
	);

	div_restoring #(.DATA_WIDTH(DATA_WIDTH)) u_div_restoring (
		.clk(clk), .rstLow(rstLow), .start_i(div_start),
		.dividend_i(a_mag), .divisor_i(b_mag),
		.quotient_o(quotient), .remainder_o(remainder), .busy_o(div_busy)
	);

	// ******************************
	// Control and result
	// ******************************
	muldiv_control #(.DATA_WIDTH(DATA_WIDTH)) u_muldiv_control (
		.clk(clk), .rstLow(rstLow), .start_i(start_i), .funct3_i(funct3_i),
		.rs1_i(rs1_i), .rs2_i(rs2_i), .div_zero_i(div_zero), .div_ovf_i(div_ovf),
		.div_busy_i(div_busy), .div_start_o(div_start), .busy_o(busy_o)
	);

	muldiv_result #(.DATA_WIDTH(DATA_WIDTH)) u_muldiv_result (
		.funct3_i(funct3_i), .rs1_i(rs1_i), .product_i(product),
		.quotient_i(quotient), .remainder_i(remainder),
		.div_zero_i(div_zero), .div_ovf_i(div_ovf), .sign_diff_i(sign_diff),
		.c_o(c_o)
	);

endmodule

//--- test/muldiv_vectors.svh
// Test vector entry type, directed vector table and M-extension reference model.

`ifndef MULDIV_VECTORS_SVH
`define MULDIV_VECTORS_SVH

typedef logic [DATA_WIDTH-1:0]          word_t;  // One operand or result.
typedef logic signed [2*DATA_WIDTH-1:0] dword_t; // Room for any exact product.

typedef struct {
	string   name; // Printed in every result line.
	funct3_t f3;
	word_t   rs1;
	word_t   rs2;
	word_t   exp;  // Expected c_o.
} vec_t;

vec_t vectors[$]; // Neighbours in this order form the remainder repeats.

function automatic void add_vec(string name, funct3_t f3, word_t a, word_t b, word_t exp);
	vec_t v;
	v.name = name;
	v.f3   = f3;
	v.rs1  = a;
	v.rs2  = b;
	v.exp  = exp;
	vectors.push_back(v);
endfunction

// ******************************
// Reference model
// ******************************
function automatic word_t model_result(funct3_t f3, word_t a, word_t b);
	dword_t sa;
	dword_t sb;
	dword_t ua;
	dword_t ub;
	dword_t p;
	word_t  most_neg;
	word_t  res;
	most_neg = {1'b1, {(DATA_WIDTH-1){1'b0}}};
	sa = $signed(a);                 // Sign extended.
	sb = $signed(b);
	ua = {{DATA_WIDTH{1'b0}}, a};    // Zero extended.
	ub = {{DATA_WIDTH{1'b0}}, b};
	p  = '0;
	res = '0;
	case (f3)
		FUNCT3_MUL: begin
			p = sa * sb;
			res = p[DATA_WIDTH-1:0];
		end
		FUNCT3_MULH: begin
			p = sa * sb;
			res = p[2*DATA_WIDTH-1:DATA_WIDTH];
		end
		FUNCT3_MULHSU: begin
			p = sa * ub; // Signed rs1 times unsigned rs2.
			res = p[2*DATA_WIDTH-1:DATA_WIDTH];
		end
		FUNCT3_MULHU: begin
			p = ua * ub;
			res = p[2*DATA_WIDTH-1:DATA_WIDTH];
		end
		// Division truncates toward zero and the remainder follows the dividend.
		FUNCT3_DIV: begin
			if (b == '0) res = '1;
			else if ((a == most_neg) && (b == '1)) res = a;
			else res = $signed(a) / $signed(b);
		end
		FUNCT3_DIVU: res = (b == '0) ? '1 : a / b;
		FUNCT3_REM: begin
			if (b == '0) res = a;
			else if ((a == most_neg) && (b == '1)) res = '0;
			else res = $signed(a) % $signed(b);
		end
		default: res = (b == '0) ? a : a % b; // REMU.
	endcase
	return res;
endfunction

// ******************************
// Directed vectors
// ******************************
task automatic load_directed();
	// Multiply corners with minus one, most negative and zero.
	add_vec("mul_m1_m1",     FUNCT3_MUL,    32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'h0000_0001);
	add_vec("mulh_m1_m1",    FUNCT3_MULH,   32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'h0000_0000);
	add_vec("mulhsu_m1_m1",  FUNCT3_MULHSU, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'hFFFF_FFFF);
	add_vec("mulhu_m1_m1",   FUNCT3_MULHU,  32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'hFFFF_FFFE);
	add_vec("mul_min_m1",    FUNCT3_MUL,    32'h8000_0000, 32'hFFFF_FFFF, 32'h8000_0000);
	add_vec("mulh_min_m1",   FUNCT3_MULH,   32'h8000_0000, 32'hFFFF_FFFF, 32'h0000_0000);
	add_vec("mulhsu_min_m1", FUNCT3_MULHSU, 32'h8000_0000, 32'hFFFF_FFFF, 32'h8000_0000);
	add_vec("mulhu_min_m1",  FUNCT3_MULHU,  32'h8000_0000, 32'hFFFF_FFFF, 32'h7FFF_FFFF);
	add_vec("mulh_min_min",  FUNCT3_MULH,   32'h8000_0000, 32'h8000_0000, 32'h4000_0000);
	add_vec("mulhsu_min_min", FUNCT3_MULHSU, 32'h8000_0000, 32'h8000_0000, 32'hC000_0000);
	add_vec("mul_min_min",   FUNCT3_MUL,    32'h8000_0000, 32'h8000_0000, 32'h0000_0000);
	add_vec("mulh_m1_zero",  FUNCT3_MULH,   32'hFFFF_FFFF, 32'h0000_0000, 32'h0000_0000);
	add_vec("mulhsu_zero_m1", FUNCT3_MULHSU, 32'h0000_0000, 32'hFFFF_FFFF, 32'h0000_0000);
	// Divide by zero and signed overflow answered without the divider.
	add_vec("div_by_zero",   FUNCT3_DIV,    32'h0000_1234, 32'h0000_0000, 32'hFFFF_FFFF);
	add_vec("divu_by_zero",  FUNCT3_DIVU,   32'hFFFF_0000, 32'h0000_0000, 32'hFFFF_FFFF);
	add_vec("rem_by_zero",   FUNCT3_REM,    32'h8000_0001, 32'h0000_0000, 32'h8000_0001);
	add_vec("remu_by_zero",  FUNCT3_REMU,   32'h0000_0007, 32'h0000_0000, 32'h0000_0007);
	add_vec("div_ovf",       FUNCT3_DIV,    32'h8000_0000, 32'hFFFF_FFFF, 32'h8000_0000);
	add_vec("rem_ovf",       FUNCT3_REM,    32'h8000_0000, 32'hFFFF_FFFF, 32'h0000_0000);
	add_vec("divu_min_m1",   FUNCT3_DIVU,   32'h8000_0000, 32'hFFFF_FFFF, 32'h0000_0000);
	// Quotient then remainder pairs on the same operands.
	add_vec("div_m7_2",      FUNCT3_DIV,    32'hFFFF_FFF9, 32'h0000_0002, 32'hFFFF_FFFD);
	add_vec("rem_m7_2",      FUNCT3_REM,    32'hFFFF_FFF9, 32'h0000_0002, 32'hFFFF_FFFF);
	add_vec("div_p100_m7",   FUNCT3_DIV,    32'h0000_0064, 32'hFFFF_FFF9, 32'hFFFF_FFF2);
	add_vec("rem_p100_m7",   FUNCT3_REM,    32'h0000_0064, 32'hFFFF_FFF9, 32'h0000_0002);
	add_vec("div_7_m2",      FUNCT3_DIV,    32'h0000_0007, 32'hFFFF_FFFE, 32'hFFFF_FFFD);
	add_vec("remu_7_m2",     FUNCT3_REMU,   32'h0000_0007, 32'hFFFF_FFFE, 32'h0000_0007);
	add_vec("divu_100_7",    FUNCT3_DIVU,   32'h0000_0064, 32'h0000_0007, 32'h0000_000E);
	add_vec("remu_100_7",    FUNCT3_REMU,   32'h0000_0064, 32'h0000_0007, 32'h0000_0002);
	// Remainder after a quotient on a changed divisor or dividend runs the divider.
	add_vec("div_m9_4",      FUNCT3_DIV,    32'hFFFF_FFF7, 32'h0000_0004, 32'hFFFF_FFFE);
	add_vec("rem_m9_5",      FUNCT3_REM,    32'hFFFF_FFF7, 32'h0000_0005, 32'hFFFF_FFFC);
	add_vec("div_m9_5",      FUNCT3_DIV,    32'hFFFF_FFF7, 32'h0000_0005, 32'hFFFF_FFFF);
	add_vec("rem_m8_5",      FUNCT3_REM,    32'hFFFF_FFF8, 32'h0000_0005, 32'hFFFF_FFFD);
endtask

`endif

//--- test/muldiv_unit_tb.sv
// Testbench of the multiply and divide unit with clock, reset, vector loop, checks and timeout.

module muldiv_unit_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import muldiv_pkg::*;

	localparam int DATA_WIDTH     = DATA_WIDTH_DEF;
	localparam int RESET_CYCLES   = 2;
	localparam int CYCLES_PER_VEC = DATA_WIDTH + 4; // Longest vector plus the idle gap.
	localparam int TIMEOUT_MARGIN = 20;
	localparam int RAND_MULS      = 8;
	localparam int RAND_DIVS      = 16;

	`include "muldiv_vectors.svh"

	logic    clk;
	logic    rstLow;
	logic    start_i;
	funct3_t funct3_i;
	word_t   rs1_i;
	word_t   rs2_i;
	word_t   c_o;
	logic    busy_o;

	int      seed = 32'h3576;
	int      cycle_count = 0;
	int      cycle_limit = 0; // Set once the table is built.
	int      pass_count;
	int      fail_count;
	funct3_t prev_f3;         // Last request that was not a repeat.
	word_t   prev_a;          // Operands of the last divide that ran.
	word_t   prev_b;

	muldiv_unit #(.DATA_WIDTH(DATA_WIDTH)) UUT (
		.clk(clk), .rstLow(rstLow), .start_i(start_i),
		.rs1_i(rs1_i), .rs2_i(rs2_i), .funct3_i(funct3_i),
		.c_o(c_o), .busy_o(busy_o)
	);

	// ******************************
	// Clock and timeout
	// ******************************
	initial clk = 1'b0;
	always #20 clk = ~clk; // 40 ns period.

	always @(posedge clk) cycle_count <= cycle_count + 1;

	initial begin
		wait (cycle_limit > 0);
		while (cycle_count < cycle_limit) begin
			@(posedge clk);
		end
		$display("Run stopped after %0d cycles, busy_o never fell", cycle_count);
		$display("test failed");
		$finish;
	end

	// ******************************
	// Expected busy length
	// ******************************
	// REM right after DIV, or REMU after DIVU, on the same operands.
	function automatic bit is_repeat(funct3_t f3, word_t a, word_t b);
		return (((f3 == FUNCT3_REM) && (prev_f3 == FUNCT3_DIV)) ||
			((f3 == FUNCT3_REMU) && (prev_f3 == FUNCT3_DIVU))) &&
			(a == prev_a) && (b == prev_b);
	endfunction

	function automatic int expect_busy(funct3_t f3, word_t a, word_t b);
		word_t most_neg;
		most_neg = {1'b1, {(DATA_WIDTH-1){1'b0}}};
		if (!f3[2]) return 1;                // Multiply, start cycle only.
		if (b == '0) return 0;               // Divide by zero.
		if (((f3 == FUNCT3_DIV) || (f3 == FUNCT3_REM)) && (a == most_neg) && (b == '1))
			return 0;                        // Signed overflow.
		if (is_repeat(f3, a, b)) return 0;   // Held remainder.
		return DATA_WIDTH + 1;
	endfunction

	// ******************************
	// Random vectors
	// ******************************
	task automatic load_random();
		word_t   a;
		word_t   b;
		funct3_t f3;
		for (int i = 0; i < RAND_MULS; i++) begin
			f3 = funct3_t'(i % 4);
			a = $random(seed);
			b = $random(seed);
			add_vec($sformatf("rand_f%0d_%0d", f3, i), f3, a, b, model_result(f3, a, b));
		end
		for (int i = 0; i < RAND_DIVS; i++) begin
			f3 = funct3_t'(4 + (i % 4));
			a = $random(seed);
			b = $random(seed) >>> ((i % 7) * 4); // Smaller divisors, sign kept.
			add_vec($sformatf("rand_f%0d_%0d", f3, i), f3, a, b, model_result(f3, a, b));
		end
	endtask

	// ******************************
	// One vector
	// ******************************
	task automatic run_vector(input vec_t v);
		int busy_cycles;
		int busy_exp;
		bit repeat_hit;
		bit ok;
		busy_exp = expect_busy(v.f3, v.rs1, v.rs2);
		repeat_hit = is_repeat(v.f3, v.rs1, v.rs2);
		ok = 1'b1;
		@(posedge clk);
		rs1_i    <= v.rs1;
		rs2_i    <= v.rs2;
		funct3_i <= v.f3;
		start_i  <= 1'b1;
		@(negedge clk);
		busy_cycles = 0;
		while (busy_o) begin
			busy_cycles++;
			@(posedge clk);
			start_i <= 1'b0; // One-cycle strobe.
			@(negedge clk);
		end
		assert (c_o === v.exp) else begin
			$display("Fail %s expected %h actual %h", v.name, v.exp, c_o);
			ok = 1'b0;
		end
		assert (busy_cycles == busy_exp) else begin
			$display("busy_o was high for %0d cycles in %s instead of %0d",
				busy_cycles, v.name, busy_exp);
			ok = 1'b0;
		end
		if (ok) begin
			pass_count++;
			$display("ok   %s c_o %h busy %0d", v.name, c_o, busy_cycles);
		end else begin
			fail_count++;
		end
		if (!repeat_hit) prev_f3 = v.f3;
		if (busy_exp == DATA_WIDTH + 1) begin
			prev_a = v.rs1;
			prev_b = v.rs2;
		end
		@(posedge clk);
		start_i <= 1'b0; // Idle gap, also ends a fast start.
	endtask

	// ******************************
	// Main sequence
	// ******************************
	initial begin
		rstLow     = 1'b0;
		start_i    = 1'b0;
		funct3_i   = FUNCT3_MUL;
		rs1_i      = '0;
		rs2_i      = '0;
		pass_count = 0;
		fail_count = 0;
		prev_f3    = FUNCT3_MUL; // Matches the control after reset.
		prev_a     = '0;
		prev_b     = '0;
		load_directed();
		load_random();
		cycle_limit = vectors.size() * CYCLES_PER_VEC + TIMEOUT_MARGIN;
		repeat (RESET_CYCLES) @(posedge clk);
		rstLow <= 1'b1;
		@(negedge clk);
		assert (busy_o === 1'b0) else begin
			$display("busy_o is not low after reset");
			fail_count++;
		end
		if (busy_o === 1'b0) begin
			pass_count++;
			$display("ok   reset_busy");
		end
		foreach (vectors[i]) run_vector(vectors[i]);
		$display("Summary %0d ok, %0d wrong", pass_count, fail_count);
		if (fail_count == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

//--- muldiv_unit.f
+incdir+test
logic/muldiv_pkg.sv
logic/operand_unsign.sv
logic/mul_array.sv
logic/div_restoring.sv
logic/muldiv_control.sv
logic/muldiv_result.sv
logic/muldiv_unit.sv
test/muldiv_unit_tb.sv
